// ==== tetrisPixelRenderer.f ====
+incdir+hdl
hdl/tetrisPkg.sv
hdl/cellDecode.sv
hdl/cellOccupancy.sv
hdl/pixelColor.sv
hdl/tetrisPixelRenderer.sv
sim/tbClock.sv
sim/tbTetrisPixelRenderer.sv

// ==== runSim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
if [ $? -ne 0 ]; then
	echo "could not clean old build"
	exit 1
fi

verilator --binary --timing --assert \
	-f tetrisPixelRenderer.f \
	--top-module tbTetrisPixelRenderer \
	-o simTetris
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/simTetris > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim/tbTetrisPixelRenderer.sv ====
`timescale 1ns/10ps

`include "tetrisBoard_defs.svh"

module tbTetrisPixelRenderer;

	import tetrisPkg::*;

	logic Clk;
	logic reset;
	logic bright;
	pixelCoord_t hCount;
	pixelCoord_t vCount;
	boardBits_t boardCells;
	pieceCoords_t pieceX;
	pieceCoords_t pieceY;
	rgb_t rgb;

	rgb_t [2:0] expLine;
	logic [2:0] expValid;
	int quietCycles = 0;
	logic [31:0] lfsrState = 32'hafe142e4;
	string testName = "resetBlack";
	int errorCount = 0;
	int testErrorBase = 0;
	int passCount = 0;
	int failCount = 0;

	tbClock clockGen
	(
		.Clk   (Clk),
		.reset (reset)
	);

	tetrisPixelRenderer UUT
	(
		.Clk        (Clk),
		.reset      (reset),
		.bright     (bright),
		.hCount     (hCount),
		.vCount     (vCount),
		.boardCells (boardCells),
		.pieceX     (pieceX),
		.pieceY     (pieceY),
		.rgb        (rgb)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic rgb_t expectedColor(logic b, pixelCoord_t h, pixelCoord_t v,
		boardBits_t board, pieceCoords_t px, pieceCoords_t py);
		int hOff;
		int vOff;
		int col;
		int row;
		logic inCellM;
		logic inFrameM;
		logic filledM;
		hOff = int'(h) - `BOARD_LEFT;
		vOff = `BOARD_BOTTOM - int'(v);
		inCellM = 1'b0;
		filledM = 1'b0;
		if ((hOff >= 0) && (vOff >= 0))
		begin
			col = hOff / `CELL_PITCH;
			row = vOff / `CELL_PITCH;
			inCellM = ((hOff % `CELL_PITCH) < `CELL_SIZE) &&
				((vOff % `CELL_PITCH) < `CELL_SIZE) &&
				(col < `BOARD_COLS) && (row < `BOARD_ROWS);
		end
		if (inCellM)
		begin
			filledM = board[row * `BOARD_COLS + col];
			for (int i = 0; i < `PIECE_CELLS; i++)
			begin
				if ((int'(py[i]) == row) && (int'(px[i]) == col))
					filledM = 1'b1;
			end
		end
		inFrameM = (int'(h) >= `FRAME_LEFT) && (int'(h) <= `FRAME_RIGHT) &&
			(int'(v) >= `FRAME_TOP) && (int'(v) <= `FRAME_BOTTOM);
		if (!b)
			return `COLOR_BLACK;
		else if (filledM)
			return `COLOR_LIGHT_GREY;
		else if (inFrameM)
			return `COLOR_GREY;
		return `COLOR_BLACK;
	endfunction

	// Three deep, matching the pipe latency
	always_ff @(posedge Clk)
	begin
		expLine[0] <= expectedColor(bright, hCount, vCount, boardCells, pieceX, pieceY);
		expLine[1] <= expLine[0];
		expLine[2] <= expLine[1];
		expValid <= {expValid[1:0], (!reset && (quietCycles == 0))};
		if (reset)
			quietCycles <= 3;
		else if (quietCycles != 0)
			quietCycles <= quietCycles - 1;
	end

	resetWindowBlack: assert property (@(posedge Clk)
		(quietCycles != 0) |-> (rgb == `COLOR_BLACK))
	else
	begin
		errorCount++;
		$display("mismatch %s expected %h actual %h", testName, `COLOR_BLACK, $sampled(rgb));
	end

	modelMatch: assert property (@(posedge Clk) expValid[2] |-> (rgb == expLine[2]))
	else
	begin
		errorCount++;
		$display("mismatch %s expected %h actual %h", testName, $sampled(expLine[2]),
			$sampled(rgb));
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randomBits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	task automatic drivePixel(logic b, int h, int v);
		@(posedge Clk);
		bright <= b;
		hCount <= pixelCoord_t'(h);
		vCount <= pixelCoord_t'(v);
	endtask

	task automatic driveCellCentre(logic b, int row, int col);
		drivePixel(b, `BOARD_LEFT + `CELL_PITCH * col + 13, `BOARD_BOTTOM - `CELL_PITCH * row - 13);
	endtask

	// Idle pixels until the pipe is empty
	task automatic flushPipe();
		repeat (4) drivePixel(1'b0, 0, 0);
	endtask

	task automatic beginTest(string name);
		testName = name;
		testErrorBase = errorCount;
	endtask

	task automatic endTest();
		flushPipe();
		if (errorCount == testErrorBase)
		begin
			passCount++;
			$display("test %s ok", testName);
		end
		else
		begin
			failCount++;
			$display("test %s failed with %0d errors", testName, errorCount - testErrorBase);
		end
	endtask

	task automatic waitResetRelease();
		int n;
		n = 0;
		do
		begin
			@(posedge Clk);
			n++;
		end
		while (reset && (n < 100));
		if (reset)
		begin
			errorCount++;
			$display("reset was never released");
		end
	endtask

	initial
	begin
		repeat (5000) @(posedge Clk);
		$display("simulation ran out of time");
		$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////
	// Tests
	//////////////////////////////

	initial
	begin
		// Lit frame pixel held through reset
		bright = 1'b1;
		hCount = pixelCoord_t'(`BOARD_LEFT + 13);
		vCount = pixelCoord_t'(`BOARD_BOTTOM - 13);
		boardCells = '0;
		pieceX = {`PIECE_CELLS{4'hF}};
		pieceY = {`PIECE_CELLS{4'hF}};

		beginTest("resetBlack");
		waitResetRelease();
		endTest();

		beginTest("blankingBlack");
		@(posedge Clk);
		boardCells <= '1;
		for (int i = 0; i < 12; i++)
			driveCellCentre(1'b0, i, i % `BOARD_COLS);
		drivePixel(1'b0, 299, 75);
		endTest();

		beginTest("gapAndFrame");
		@(posedge Clk);
		boardCells <= '0;
		drivePixel(1'b1, 326, 390);
		drivePixel(1'b1, 353, 300);
		drivePixel(1'b1, 320, 374);
		drivePixel(1'b1, 299, 200);
		drivePixel(1'b1, 569, 401);
		driveCellCentre(1'b1, 4, 6);
		drivePixel(1'b1, 298, 200);
		drivePixel(1'b1, 570, 200);
		drivePixel(1'b1, 400, 74);
		drivePixel(1'b1, 400, 402);
		endTest();

		beginTest("settledBoard");
		@(posedge Clk);
		boardCells <= {24'(randomBits(24)), randomBits(32), randomBits(32), randomBits(32)};
		for (int r = 0; r < `BOARD_ROWS; r++)
			for (int c = 0; c < `BOARD_COLS; c++)
				driveCellCentre(1'b1, r, c);
		endTest();

		// Cell (2,7) shares a row and a column with two different piece cells
		beginTest("pieceCells");
		@(posedge Clk);
		boardCells <= '0;
		pieceY <= {4'd13, 4'd5, 4'd2, 4'd2};
		pieceX <= {4'd1, 4'd7, 4'd4, 4'd3};
		for (int r = 0; r < `BOARD_ROWS; r++)
			for (int c = 0; c < `BOARD_COLS; c++)
				driveCellCentre(1'b1, r, c);
		endTest();

		beginTest("pixelStream");
		@(posedge Clk);
		pieceY <= {cellCoord_t'(randomBits(4)), cellCoord_t'(randomBits(4)),
			cellCoord_t'(randomBits(4)), cellCoord_t'(randomBits(4))};
		pieceX <= {cellCoord_t'(randomBits(4)), cellCoord_t'(randomBits(4)),
			cellCoord_t'(randomBits(4)), cellCoord_t'(randomBits(4))};
		for (int i = 0; i < 300; i++)
			drivePixel(randomBits(3) != 0, 290 + int'(randomBits(9)) % 290,
				65 + int'(randomBits(9)) % 345);
		endTest();

		$display("tests passed %0d failed %0d", passCount, failCount);
		if ((failCount == 0) && (errorCount == 0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== sim/tbClock.sv ====
`timescale 1ns/10ps

module tbClock
(
	output logic Clk,
	output logic reset
);

	// 100 ns period
	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// Reset held for the first 10 rising edges
	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge Clk);
		reset <= 1'b0;
	end

endmodule

// ==== hdl/tetrisPixelRenderer.sv ====
`timescale 1ns/10ps

module tetrisPixelRenderer
(
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    bright,
	input  tetrisPkg::pixelCoord_t  hCount,
	input  tetrisPkg::pixelCoord_t  vCount,
	input  tetrisPkg::boardBits_t   boardCells,
	input  tetrisPkg::pieceCoords_t pieceX,
	input  tetrisPkg::pieceCoords_t pieceY,
	output tetrisPkg::rgb_t         rgb
);

	import tetrisPkg::*;

	//////////////////////////////
	// Decode to occupancy
	//////////////////////////////

	cellCoord_t cellRow;
	cellCoord_t cellCol;
	logic       inCell;
	logic       inFrame;
	logic       brightD;

	//////////////////////////////
	// Occupancy to colour
	//////////////////////////////

	logic filled;
	logic inCellE;
	logic inFrameE;
	logic brightE;

	cellDecode decodeStage
	(
		.Clk     (Clk),
		.reset   (reset),
		.bright  (bright),
		.hCount  (hCount),
		.vCount  (vCount),
		.cellRow (cellRow),
		.cellCol (cellCol),
		.inCell  (inCell),
		.inFrame (inFrame),
		.brightD (brightD)
	);

	cellOccupancy occupancyStage
	(
		.Clk        (Clk),
		.reset      (reset),
		.cellRow    (cellRow),
		.cellCol    (cellCol),
		.inCell     (inCell),
		.inFrame    (inFrame),
		.brightD    (brightD),
		.boardCells (boardCells),
		.pieceX     (pieceX),
		.pieceY     (pieceY),
		.filled     (filled),
		.inCellE    (inCellE),
		.inFrameE   (inFrameE),
		.brightE    (brightE)
	);

	pixelColor colorStage
	(
		.Clk      (Clk),
		.reset    (reset),
		.filled   (filled),
		.inCellE  (inCellE),
		.inFrameE (inFrameE),
		.brightE  (brightE),
		.rgb      (rgb)
	);

endmodule

// ==== hdl/pixelColor.sv ====
`timescale 1ns/10ps

`include "tetrisBoard_defs.svh"

module pixelColor
(
	input  logic            Clk,
	input  logic            reset,
	input  logic            filled,
	input  logic            inCellE,
	input  logic            inFrameE,
	input  logic            brightE,
	output tetrisPkg::rgb_t rgb
);

	import tetrisPkg::*;

	rgb_t nextColor;

	// Blanking wins over everything
	always_comb
	begin
		if (!brightE)
			nextColor = `COLOR_BLACK;
		else if (filled && inCellE)
			nextColor = `COLOR_LIGHT_GREY;
		else if (inFrameE)
			nextColor = `COLOR_GREY;
		else
			nextColor = `COLOR_BLACK;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			rgb <= `COLOR_BLACK;
		else
			rgb <= nextColor;
	end

	// Only the three board colours ever leave the pipe
	rgbLegal: assert property (@(posedge Clk)
		(rgb == `COLOR_BLACK) || (rgb == `COLOR_GREY) || (rgb == `COLOR_LIGHT_GREY));

endmodule

// ==== hdl/cellOccupancy.sv ====
`timescale 1ns/10ps

`include "tetrisBoard_defs.svh"

module cellOccupancy
(
	input  logic                    Clk,
	input  logic                    reset,
	input  tetrisPkg::cellCoord_t   cellRow,
	input  tetrisPkg::cellCoord_t   cellCol,
	input  logic                    inCell,
	input  logic                    inFrame,
	input  logic                    brightD,
	input  tetrisPkg::boardBits_t   boardCells,
	input  tetrisPkg::pieceCoords_t pieceX,
	input  tetrisPkg::pieceCoords_t pieceY,
	output logic                    filled,
	output logic                    inCellE,
	output logic                    inFrameE,
	output logic                    brightE
);

	import tetrisPkg::*;

	logic [$clog2(`BOARD_ROWS*`BOARD_COLS)-1:0] boardIdx;
	logic boardBit;
	logic pieceHit;

	assign boardIdx = $bits(boardIdx)'(cellRow) * $bits(boardIdx)'(`BOARD_COLS) +
		$bits(boardIdx)'(cellCol);
	assign boardBit = boardCells[boardIdx];

	// Row and column must come from the same piece cell
	always_comb
	begin
		pieceHit = 1'b0;
		for (int i = 0; i < `PIECE_CELLS; i++)
		begin
			if ((pieceY[i] < cellCoord_t'(`BOARD_ROWS)) && (pieceX[i] < cellCoord_t'(`BOARD_COLS)) &&
				(pieceY[i] == cellRow) && (pieceX[i] == cellCol))
				pieceHit = 1'b1;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			filled   <= 1'b0;
			inCellE  <= 1'b0;
			inFrameE <= 1'b0;
			brightE  <= 1'b0;
		end
		else
		begin
			filled   <= inCell && (boardBit || pieceHit);
			inCellE  <= inCell;
			inFrameE <= inFrame;
			brightE  <= brightD;
		end
	end

endmodule

// ==== hdl/cellDecode.sv ====
`timescale 1ns/10ps

`include "tetrisBoard_defs.svh"

module cellDecode
(
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   bright,
	input  tetrisPkg::pixelCoord_t hCount,
	input  tetrisPkg::pixelCoord_t vCount,
	output tetrisPkg::cellCoord_t  cellRow,
	output tetrisPkg::cellCoord_t  cellCol,
	output logic                   inCell,
	output logic                   inFrame,
	output logic                   brightD
);

	import tetrisPkg::*;

	cellCoord_t colIdx;
	cellCoord_t rowIdx;
	logic       colHit;
	logic       rowHit;
	logic       frameHit;

	// Column c starts at BOARD_LEFT + c * pitch
	always_comb
	begin
		colHit = 1'b0;
		colIdx = '0;
		for (int c = 0; c < `BOARD_COLS; c++)
		begin
			if ((hCount >= pixelCoord_t'(`BOARD_LEFT + `CELL_PITCH * c)) &&
				(hCount <= pixelCoord_t'(`BOARD_LEFT + `CELL_PITCH * c + `CELL_SIZE - 1)))
			begin
				colHit = 1'b1;
				colIdx = cellCoord_t'(c);
			end
		end
	end

	// Row 0 sits at the bottom, rows grow upwards
	always_comb
	begin
		rowHit = 1'b0;
		rowIdx = '0;
		for (int r = 0; r < `BOARD_ROWS; r++)
		begin
			if ((vCount >= pixelCoord_t'(`BOARD_BOTTOM - `CELL_PITCH * r - `CELL_SIZE + 1)) &&
				(vCount <= pixelCoord_t'(`BOARD_BOTTOM - `CELL_PITCH * r)))
			begin
				rowHit = 1'b1;
				rowIdx = cellCoord_t'(r);
			end
		end
	end

	assign frameHit = (hCount >= pixelCoord_t'(`FRAME_LEFT)) &&
		(hCount <= pixelCoord_t'(`FRAME_RIGHT)) &&
		(vCount >= pixelCoord_t'(`FRAME_TOP)) &&
		(vCount <= pixelCoord_t'(`FRAME_BOTTOM));

	always_ff @(posedge Clk)
	begin
		cellRow <= rowIdx;
		cellCol <= colIdx;
		if (reset)
		begin
			inCell  <= 1'b0;
			inFrame <= 1'b0;
			brightD <= 1'b0;
		end
		else
		begin
			inCell  <= colHit && rowHit;
			inFrame <= frameHit;
			brightD <= bright;
		end
	end

	//////////////////////////////
	// Checks on the decode result
	//////////////////////////////

	cellInsideFrame: assert property (@(posedge Clk) disable iff (reset)
		inCell |-> inFrame);

	cellIndexInRange: assert property (@(posedge Clk) disable iff (reset)
		inCell |-> ((cellCol < `BOARD_COLS) && (cellRow < `BOARD_ROWS)));

endmodule

// ==== hdl/tetrisPkg.sv ====
`include "tetrisBoard_defs.svh"

package tetrisPkg;

	// hCount or vCount
	typedef logic [`PIXEL_BITS-1:0] pixelCoord_t;

	// Row or column index on the board
	typedef logic [`CELL_BITS-1:0] cellCoord_t;

	// Red, green, blue from msb down
	typedef logic [`COLOR_BITS-1:0] rgb_t;

	// Bit row * BOARD_COLS + col set for a settled cell
	typedef logic [`BOARD_ROWS*`BOARD_COLS-1:0] boardBits_t;

	// One coordinate per cell of the falling piece
	typedef cellCoord_t [`PIECE_CELLS-1:0] pieceCoords_t;

endpackage

// ==== hdl/tetrisBoard_defs.svh ====
`ifndef TETRIS_BOARD_DEFS_SVH
`define TETRIS_BOARD_DEFS_SVH

//////////////////////////////
// Board geometry
//////////////////////////////

`define BOARD_COLS   10
`define BOARD_ROWS   12
`define PIECE_CELLS  4

// Cell pitch includes the one pixel gap
`define CELL_PITCH   27
`define CELL_SIZE    26

`define BOARD_LEFT   300
`define BOARD_BOTTOM 400

// Grey frame, inclusive bounds
`define FRAME_LEFT   299
`define FRAME_RIGHT  569
`define FRAME_TOP    75
`define FRAME_BOTTOM 401

`define PIXEL_BITS   10
`define CELL_BITS    4
`define COLOR_BITS   12

//////////////////////////////
// Colours, 4 bits per channel
//////////////////////////////

`define COLOR_BLACK      12'h000
`define COLOR_GREY       12'h333
`define COLOR_LIGHT_GREY 12'hAAA

`endif
